/* Makefile */
VERILATOR ?= verilator
TOP       ?= fp_mul_tb
FLIST     ?= fp_mul.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  := TESTS FAILED

SRCS := $(wildcard src/*.sv) $(wildcard testbench/*.sv) $(wildcard include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* fp_mul.f */
+incdir+include
src/fp_pkg.sv
src/fp_stage_if.sv
src/fp_mul_product.sv
src/fp_normalizer.sv
src/fp_round_pack.sv
src/fp_mul.sv
testbench/fp_mul_asserts.sv
testbench/fp_mul_tb.sv

/* include/fp_defs.svh */
`ifndef FP_DEFS_SVH
`define FP_DEFS_SVH

////////////////////////////////////////
// Binary32 format
////////////////////////////////////////

`define FP_EXP_W    8               // Exponent field.
`define FP_MAN_W    23              // Stored fraction.
`define FP_SIG_W    24              // Fraction plus hidden bit.
`define FP_PROD_W   48              // Full significand product.
`define FP_SHIFT_W  6               // Normalizer shift amount.

`define FP_BIAS     127
`define FP_EXP_MAX  255             // All-ones exponent.
`define FP_QNAN     32'h7FC00000    // Canonical quiet NaN.

////////////////////////////////////////
// Pipeline
////////////////////////////////////////

`define FP_LATENCY  3               // Input to output, in cycles.

`endif

/* src/fp_mul.sv */
`default_nettype none

module fp_mul
	import fp_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      in_valid,
	input  fp_word_t  a,
	input  fp_word_t  b,
	output logic      out_valid,
	output fp_word_t  result,
	output fp_flags_t flags
);

	////////////////////////////////////////
	// Stage links
	////////////////////////////////////////

	fp_stage_if #(.payload_t(fp_prod_t)) prod_if ();
	fp_stage_if #(.payload_t(fp_norm_t)) norm_if ();

	////////////////////////////////////////
	// Three-stage pipeline
	////////////////////////////////////////

	// Unpack, classify, 24 x 24 multiply.
	fp_mul_product u_product
	(
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.a        (a),
		.b        (b),
		.prod     (prod_if.src)
	);

	// Leading-zero count and left shift.
	fp_normalizer u_normalizer
	(
		.clk  (clk),
		.rst  (rst),
		.prod (prod_if.dst),
		.norm (norm_if.src)
	);

	fp_round_pack u_round_pack
	(
		.clk       (clk),
		.rst       (rst),
		.norm      (norm_if.dst),
		.out_valid (out_valid),
		.result    (result),
		.flags     (flags)
	);

endmodule

`default_nettype wire

/* src/fp_mul_product.sv */
`default_nettype none

`include "fp_defs.svh"

module fp_mul_product
	import fp_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     in_valid,
	input  fp_word_t a,
	input  fp_word_t b,
	fp_stage_if.src  prod
);

	logic [`FP_EXP_W-1:0] exp_a, exp_b;
	logic [`FP_MAN_W-1:0] man_a, man_b;
	logic [`FP_EXP_W-1:0] eff_a, eff_b;
	logic [`FP_SIG_W-1:0] sig_a, sig_b;
	logic                 zero_a, zero_b;
	logic                 inf_a, inf_b;
	logic                 nan_a, nan_b;
	logic                 inf_times_zero;
	logic                 snan_in;
	fp_special_t          special;
	fp_prod_t             prod_next;

	////////////////////////////////////////
	// Unpack
	////////////////////////////////////////

	assign exp_a = a[30:23];
	assign exp_b = b[30:23];
	assign man_a = a[`FP_MAN_W-1:0];
	assign man_b = b[`FP_MAN_W-1:0];

	assign eff_a = (exp_a == '0) ? `FP_EXP_W'(1) : exp_a; // Subnormals use 1.
	assign eff_b = (exp_b == '0) ? `FP_EXP_W'(1) : exp_b;
	assign sig_a = {exp_a != '0, man_a};
	assign sig_b = {exp_b != '0, man_b};

	assign zero_a = (exp_a == '0) && (man_a == '0);
	assign zero_b = (exp_b == '0) && (man_b == '0);
	assign inf_a  = (exp_a == `FP_EXP_W'(`FP_EXP_MAX)) && (man_a == '0);
	assign inf_b  = (exp_b == `FP_EXP_W'(`FP_EXP_MAX)) && (man_b == '0);
	assign nan_a  = (exp_a == `FP_EXP_W'(`FP_EXP_MAX)) && (man_a != '0);
	assign nan_b  = (exp_b == `FP_EXP_W'(`FP_EXP_MAX)) && (man_b != '0);

	assign inf_times_zero = (inf_a && zero_b) || (zero_a && inf_b);
	assign snan_in        = (nan_a && !man_a[22]) || (nan_b && !man_b[22]); // Quiet bit clear.

	always_comb
	begin
		if (nan_a || nan_b || inf_times_zero)
			special = FP_NAN;
		else if (inf_a || inf_b)
			special = FP_INF;
		else if (zero_a || zero_b)
			special = FP_ZERO;
		else
			special = FP_FINITE;
	end

	always_comb
	begin
		prod_next.sign    = a[31] ^ b[31];
		prod_next.exp     = (`FP_EXP_W+2)'({2'b00, eff_a}) + (`FP_EXP_W+2)'({2'b00, eff_b})
		                    - (`FP_EXP_W+2)'(`FP_BIAS);
		prod_next.prod    = sig_a * sig_b;   // 24 x 24.
		prod_next.special = special;
		prod_next.invalid = inf_times_zero || snan_in;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			prod.valid <= 1'b0;
		else
			prod.valid <= in_valid;
	end

	always_ff @(posedge clk)
	begin
		prod.data <= prod_next;
	end

endmodule

`default_nettype wire

/* src/fp_normalizer.sv */
`default_nettype none

`include "fp_defs.svh"

module fp_normalizer
	import fp_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	fp_stage_if.dst prod,
	fp_stage_if.src norm
);

	logic [`FP_SHIFT_W-1:0]    lz;
	logic [`FP_PROD_W-1:0]     sig_shift;
	logic signed [`FP_EXP_W+1:0] exp_adj;
	fp_special_t               special;
	fp_norm_t                  norm_next;

	////////////////////////////////////////
	// Leading-zero count
	////////////////////////////////////////

	// Highest set bit wins, all zero gives 48.
	always_comb
	begin
		lz = `FP_SHIFT_W'(`FP_PROD_W);
		for (int i = 0; i < `FP_PROD_W; i++)
		begin
			if (prod.data.prod[i])
				lz = `FP_SHIFT_W'(`FP_PROD_W - 1 - i);
		end
	end

	////////////////////////////////////////
	// Left shift, 0 to 48 places
	////////////////////////////////////////

	// Log shifter, one stage per bit of lz.
	always_comb
	begin
		sig_shift = prod.data.prod;
		for (int k = 0; k < `FP_SHIFT_W; k++)
		begin
			if (lz[k])
				sig_shift = sig_shift << (1 << k);
		end
	end

	// Leading one moves to bit 47, worth 2^(1 - lz).
	assign exp_adj = prod.data.exp + (`FP_EXP_W+2)'(1) - (`FP_EXP_W+2)'(lz);

	always_comb
	begin
		if ((prod.data.special == FP_FINITE) && (lz == `FP_SHIFT_W'(`FP_PROD_W)))
			special = FP_ZERO;   // Empty product.
		else
			special = prod.data.special;
	end

	always_comb
	begin
		norm_next.sign    = prod.data.sign;
		norm_next.exp     = exp_adj;
		norm_next.sig     = sig_shift;
		norm_next.special = special;
		norm_next.invalid = prod.data.invalid;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			norm.valid <= 1'b0;
		else
			norm.valid <= prod.valid;
	end

	always_ff @(posedge clk)
	begin
		norm.data <= norm_next;
	end

endmodule

`default_nettype wire

/* src/fp_pkg.sv */
`default_nettype none

`include "fp_defs.svh"

package fp_pkg;

	typedef logic [31:0] fp_word_t;

	typedef struct packed {
		logic invalid;
		logic overflow;
		logic underflow;
	} fp_flags_t;

	// Result class settled in stage 1.
	typedef enum logic [1:0] {
		FP_FINITE = 2'd0,
		FP_ZERO   = 2'd1,
		FP_INF    = 2'd2,
		FP_NAN    = 2'd3
	} fp_special_t;

	typedef struct packed {
		logic                            sign;
		logic signed [`FP_EXP_W+1:0]     exp;     // ea + eb - bias.
		logic        [`FP_PROD_W-1:0]    prod;
		fp_special_t                     special;
		logic                            invalid;
	} fp_prod_t;

	typedef struct packed {
		logic                            sign;
		logic signed [`FP_EXP_W+1:0]     exp;     // Exponent of bit 47.
		logic        [`FP_PROD_W-1:0]    sig;     // Leading one at bit 47.
		fp_special_t                     special;
		logic                            invalid;
	} fp_norm_t;

endpackage

`default_nettype wire

/* src/fp_round_pack.sv */
`default_nettype none

`include "fp_defs.svh"

module fp_round_pack
	import fp_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	fp_stage_if.dst   norm,
	output logic      out_valid,
	output fp_word_t  result,
	output fp_flags_t flags
);

	logic [`FP_MAN_W-1:0]        frac;
	logic                        guard;
	logic                        sticky;
	logic                        round_up;
	logic [`FP_MAN_W:0]          frac_rnd;   // Extra bit catches the carry.
	logic                        carry;
	logic signed [`FP_EXP_W+1:0] exp_rnd;
	logic                        tiny;
	logic                        huge;
	fp_word_t                    result_next;
	fp_flags_t                   flags_next;

	////////////////////////////////////////
	// Round to nearest even
	////////////////////////////////////////

	assign frac     = norm.data.sig[46:24];
	assign guard    = norm.data.sig[23];
	assign sticky   = |norm.data.sig[22:0];
	assign round_up = guard && (sticky || frac[0]);

	assign frac_rnd = {1'b0, frac} + (`FP_MAN_W+1)'(round_up);
	assign carry    = frac_rnd[`FP_MAN_W];   // Fraction wrapped to zero.
	assign exp_rnd  = norm.data.exp + (`FP_EXP_W+2)'(carry);

	assign tiny = norm.data.exp < 1;         // Checked before rounding.
	assign huge = exp_rnd >= `FP_EXP_MAX;

	////////////////////////////////////////
	// Pack
	////////////////////////////////////////

	always_comb
	begin
		result_next = {norm.data.sign, {`FP_EXP_W{1'b0}}, {`FP_MAN_W{1'b0}}};
		flags_next  = '0;

		case (norm.data.special)
			FP_FINITE:
			begin
				if (tiny)
					flags_next.underflow = 1'b1;   // Flush to signed zero.
				else if (huge)
				begin
					result_next = {norm.data.sign, {`FP_EXP_W{1'b1}}, {`FP_MAN_W{1'b0}}};
					flags_next.overflow = 1'b1;
				end
				else
					result_next = {norm.data.sign, exp_rnd[`FP_EXP_W-1:0],
					               frac_rnd[`FP_MAN_W-1:0]};
			end
			FP_ZERO:
				result_next = {norm.data.sign, {`FP_EXP_W{1'b0}}, {`FP_MAN_W{1'b0}}};
			FP_INF:
				result_next = {norm.data.sign, {`FP_EXP_W{1'b1}}, {`FP_MAN_W{1'b0}}};
			default:
				result_next = `FP_QNAN;
		endcase

		flags_next.invalid = norm.data.invalid;   // From stage 1.
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			out_valid <= 1'b0;
			flags     <= '0;
		end
		else
		begin
			out_valid <= norm.valid;
			flags     <= norm.valid ? flags_next : '0;   // Quiet between results.
		end
	end

	always_ff @(posedge clk)
	begin
		result <= result_next;
	end

endmodule

`default_nettype wire

/* src/fp_stage_if.sv */
`default_nettype none

// Plain valid strobe plus payload, no back-pressure.
interface fp_stage_if #(
	parameter type payload_t = logic
);

	logic     valid;
	payload_t data;

	modport src
	(
		output valid,
		output data
	);

	modport dst
	(
		input valid,
		input data
	);

endinterface

`default_nettype wire

/* testbench/fp_mul_asserts.sv */
`default_nettype none

`include "fp_defs.svh"

module fp_mul_asserts
	import fp_pkg::*;
(
	input logic      clk,
	input logic      rst,
	input logic      in_valid,
	input logic      out_valid,
	input fp_word_t  result,
	input fp_flags_t flags
);

	timeunit 1ns;
	timeprecision 1ps;

	int assert_errors = 0;   // Read by the testbench.

	////////////////////////////////////////
	// Pipeline protocol
	////////////////////////////////////////

	reset_quiet: assert property (@(posedge clk)
		($past(rst) || $past(rst, 2)) |-> !out_valid)
	else
	begin
		$error("out_valid high during reset or on the cycle after");
		assert_errors++;
	end

	// Each stage register may be cleared by reset.
	fixed_latency: assert property (@(posedge clk) disable iff (rst)
		!($past(rst, 1) || $past(rst, 2) || $past(rst, 3))
		|-> (out_valid == $past(in_valid, `FP_LATENCY)))
	else
	begin
		$error("out_valid does not follow in_valid by the pipeline depth");
		assert_errors++;
	end

	flags_idle: assert property (@(posedge clk) disable iff (rst)
		!out_valid |-> (flags == '0))
	else
	begin
		$error("flags set while out_valid is low");
		assert_errors++;
	end

	nan_canonical: assert property (@(posedge clk) disable iff (rst)
		(out_valid && (result[30:23] == 8'hFF) && (result[22:0] != '0))
		|-> (result == `FP_QNAN))
	else
	begin
		$error("result is a NaN other than the canonical quiet NaN");
		assert_errors++;
	end

endmodule

bind fp_mul fp_mul_asserts u_asserts
(
	.clk       (clk),
	.rst       (rst),
	.in_valid  (in_valid),
	.out_valid (out_valid),
	.result    (result),
	.flags     (flags)
);

`default_nettype wire

/* testbench/fp_mul_tb.sv */
`default_nettype none

`include "fp_defs.svh"

module fp_mul_tb
	import fp_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_DIRECTED = 22;
	localparam int NUM_RANDOM   = 200;
	localparam int TIMEOUT      = NUM_DIRECTED + NUM_RANDOM + `FP_LATENCY + 20;

	typedef struct packed {
		fp_word_t  a;
		fp_word_t  b;
		fp_word_t  res;
		fp_flags_t flg;   // {invalid, overflow, underflow}.
	} vector_t;

	logic      clk;
	logic      rst;
	logic      in_valid;
	fp_word_t  a;
	fp_word_t  b;
	logic      out_valid;
	fp_word_t  result;
	fp_flags_t flags;

	fp_word_t  exp_result_q [$];
	fp_flags_t exp_flags_q [$];
	int        issue_q [$];   // Edge at which the DUT sampled each input.

	int        run_cycles      = 0;
	logic      first_edge_seen = 1'b0;
	logic      rst_d           = 1'b0;
	int        mismatches      = 0;
	int        other_errors    = 0;
	integer    seed            = 83;

	vector_t directed [NUM_DIRECTED] = '{
		'{32'h3FC00000, 32'h40000000, 32'h40400000, 3'b000},   // 1.5 x 2.0.
		'{32'h3F800800, 32'h3F800800, 32'h3F801000, 3'b000},   // Tie keeps even fraction.
		'{32'h3F800001, 32'h3FC00000, 32'h3FC00002, 3'b000},   // Tie rounds odd fraction up.
		'{32'h3F800801, 32'h3F800800, 32'h3F801002, 3'b000},   // Above half.
		'{32'h00000001, 32'h71800000, 32'h27000000, 3'b000},   // Min subnormal x 2^100.
		'{32'h00400000, 32'h7F000000, 32'h3F800000, 3'b000},
		'{32'h00012345, 32'h4B000000, 32'h0891A280, 3'b000},
		'{32'h807FFFFF, 32'h4B000000, 32'h8BFFFFFE, 3'b000},
		'{32'h00000001, 32'h00000001, 32'h00000000, 3'b001},   // Shift of 47.
		'{32'h80000001, 32'h00000001, 32'h80000000, 3'b001},
		'{32'h7F7FFFFF, 32'h3F800000, 32'h7F7FFFFF, 3'b000},
		'{32'h00800000, 32'h3F000000, 32'h00000000, 3'b001},   // Flush to zero.
		'{32'h80800000, 32'h3F000000, 32'h80000000, 3'b001},
		'{32'h7F000000, 32'h40000000, 32'h7F800000, 3'b010},   // 2^128.
		'{32'hFF7FFFFF, 32'h7F7FFFFF, 32'hFF800000, 3'b010},
		'{32'h7F800000, 32'h00000000, 32'h7FC00000, 3'b100},   // Inf x 0.
		'{32'h7F800001, 32'h3F800000, 32'h7FC00000, 3'b100},   // Signaling NaN.
		'{32'h7FC00001, 32'h3F800000, 32'h7FC00000, 3'b000},   // Quiet NaN.
		'{32'hFF800000, 32'h40000000, 32'hFF800000, 3'b000},
		'{32'h00000000, 32'hC0000000, 32'h80000000, 3'b000},
		'{32'h7F800000, 32'h00000001, 32'h7F800000, 3'b000},
		'{32'hFF800001, 32'h00000000, 32'h7FC00000, 3'b100}
	};

	fp_mul dut
	(
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.a         (a),
		.b         (b),
		.out_valid (out_valid),
		.result    (result),
		.flags     (flags)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////////////////////////
	// Compare tasks and reference model
	////////////////////////////////////////

	task automatic check_result(input string name, input fp_word_t got, input fp_word_t want);
		if (got !== want)
		begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, want);
			mismatches++;
		end
	endtask

	task automatic check_flags(input string name, input fp_flags_t got, input fp_flags_t want);
		if (got !== want)
		begin
			$display("mismatch at %0t: %s got %b expected %b", $time, name, got, want);
			mismatches++;
		end
	endtask

	task automatic model_mul(input fp_word_t x, input fp_word_t y,
		output fp_word_t r, output fp_flags_t f);
		logic        s;
		logic        nan_x, nan_y, inf_x, inf_y, zero_x, zero_y, inv_op;
		int          ex, ey, e, m;
		logic [47:0] p, n;
		logic [24:0] keep;
		logic [23:0] rest;
		s      = x[31] ^ y[31];
		nan_x  = (x[30:23] == 8'hFF) && (x[22:0] != '0);
		nan_y  = (y[30:23] == 8'hFF) && (y[22:0] != '0);
		inf_x  = (x[30:23] == 8'hFF) && (x[22:0] == '0);
		inf_y  = (y[30:23] == 8'hFF) && (y[22:0] == '0);
		zero_x = (x[30:0] == '0);
		zero_y = (y[30:0] == '0);
		inv_op = (inf_x && zero_y) || (zero_x && inf_y);
		f      = '0;
		r      = {s, 31'd0};
		if (nan_x || nan_y || inv_op)
		begin
			r         = `FP_QNAN;
			f.invalid = inv_op || (nan_x && !x[22]) || (nan_y && !y[22]);
		end
		else if (inf_x || inf_y)
			r = {s, 8'hFF, 23'd0};
		else if (!(zero_x || zero_y))
		begin
			ex = (x[30:23] == 8'd0) ? 1 : int'(x[30:23]);
			ey = (y[30:23] == 8'd0) ? 1 : int'(y[30:23]);
			p  = 48'({x[30:23] != 8'd0, x[22:0]}) * 48'({y[30:23] != 8'd0, y[22:0]});
			m  = 47;
			while (!p[m])
				m--;                                    // Highest set bit.
			e = ex + ey - `FP_BIAS + m - 46;
			if (e < 1)
				f.underflow = 1'b1;
			else
			begin
				n    = p << (47 - m);
				keep = {1'b0, n[47:24]};
				rest = n[23:0];
				if ((rest > 24'h800000) || ((rest == 24'h800000) && keep[0]))
					keep = keep + 25'd1;
				if (keep[24])
				begin
					keep = keep >> 1;
					e    = e + 1;
				end
				if (e >= `FP_EXP_MAX)
				begin
					r          = {s, 8'hFF, 23'd0};
					f.overflow = 1'b1;
				end
				else
					r = {s, 8'(e), keep[22:0]};
			end
		end
	endtask

	task automatic drive_sample(input fp_word_t x, input fp_word_t y,
		input fp_word_t r, input fp_flags_t f);
		@(posedge clk);
		in_valid <= 1'b1;
		a        <= x;
		b        <= y;
		exp_result_q.push_back(r);
		exp_flags_q.push_back(f);
		issue_q.push_back(run_cycles + 1);
	endtask

	////////////////////////////////////////
	// Output monitor and timeout
	////////////////////////////////////////

	always @(posedge clk)
	begin
		int latency;
		run_cycles      <= rst ? run_cycles : run_cycles + 1;
		rst_d           <= rst;
		first_edge_seen <= 1'b1;
		if (rst_d && (out_valid !== 1'b0))
		begin
			$display("error at %0t: out_valid high during reset", $time);
			other_errors++;
		end
		if (out_valid === 1'b1)
		begin
			if (exp_result_q.size() == 0)
			begin
				$display("error at %0t: out_valid high with no result expected", $time);
				other_errors++;
			end
			else
			begin
				check_result("result", result, exp_result_q.pop_front());
				check_flags("flags", flags, exp_flags_q.pop_front());
				latency = run_cycles - issue_q.pop_front();
				if (latency != `FP_LATENCY)
				begin
					$display("error at %0t: result arrived after %0d cycles", $time, latency);
					other_errors++;
				end
			end
		end
		else if (first_edge_seen)
			check_flags("flags", flags, '0);   // Idle output.
	end

	always @(posedge clk)
	begin
		if (run_cycles >= TIMEOUT)
		begin
			$display("error: timeout after %0d cycles", run_cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	initial
	begin
		fp_word_t  op_a, op_b, want_r;
		fp_flags_t want_f;
		int        drain;
		int        assert_fails;
		rst      = 1'b1;
		in_valid = 1'b0;
		a        = '0;
		b        = '0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		for (int i = 0; i < NUM_DIRECTED; i++)
			drive_sample(directed[i].a, directed[i].b, directed[i].res, directed[i].flg);

		for (int i = 0; i < NUM_RANDOM; i++)
		begin
			op_a = $random(seed);
			op_b = $random(seed);
			if (i % 4 == 0)
				op_a[30:23] = '0;                      // Subnormal operand.
			if (i % 2 == 1)
				op_b[30:23] = 8'd254 - op_a[30:23];    // Product near 1.0.
			model_mul(op_a, op_b, want_r, want_f);
			drive_sample(op_a, op_b, want_r, want_f);
		end

		@(posedge clk);
		in_valid <= 1'b0;
		drain = 0;
		while ((exp_result_q.size() != 0) && (drain < `FP_LATENCY + 4))
		begin
			@(posedge clk);
			drain++;
		end
		if (exp_result_q.size() != 0)
		begin
			$display("error: %0d expected results never arrived", exp_result_q.size());
			other_errors++;
		end

		// Let the checks of the last edge settle.
		@(negedge clk);
		assert_fails = dut.u_asserts.assert_errors;
		$display("errors: %0d mismatches, %0d other, %0d assertion failures",
		         mismatches, other_errors, assert_fails);
		if (mismatches + other_errors + assert_fails == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
